// ==== dv/kcpu_props.sv ====
// kcpu bus and control assertions, bound into the core top level
`timescale 1ns/10ps
`default_nettype none

`include "kcpu_macros.svh"

module kcpu_props
    import kcpu_pkg::*;
(
    input wire                clk,
    input wire                arst_n,
    input wire                cen,
    input wire                we,
    input wire [`KCPU_AW-1:0] addr,
    input wire kcpu_state_e   state
);

    we_in_store: assert property (@(posedge clk) disable iff (!arst_n)
        we |-> state == ST_STORE)
        else $error("we was high outside the store state");

    // nothing moves the bus without a core step
    addr_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !cen |=> $stable(addr))
        else $error("addr changed in a cycle without cen");

    stop_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        state == ST_STOPPED |=> state == ST_STOPPED)
        else $error("state left the stopped state without reset");

endmodule

bind kcpu kcpu_props props_i (
    .clk    ( clk    ),
    .arst_n ( arst_n ),
    .cen    ( cen    ),
    .we     ( we     ),
    .addr   ( addr   ),
    .state  ( state  )
);

`default_nettype wire

// ==== dv/kcpu_tb.sv ====
// kcpu testbench, runs the program image and checks every bus write against the expected table
`timescale 1ns/10ps
`default_nettype none

`include "kcpu_macros.svh"

module kcpu_tb
    import kcpu_pkg::*;
();

    localparam int CLK_HALF    = 20;
    localparam int RST_CYCLES  = 8;
    localparam int HALT_CYCLES = 50;
    localparam int HALT_AFTER  = 3;
    localparam int TAIL_CYCLES = 20;
    localparam logic [`KCPU_AW-1:0] TBL_BASE  = 16'h8000;
    localparam logic [`KCPU_AW-1:0] INFO_BASE = 16'h7FFC;

    logic                clk;
    logic                arst_n;
    logic                cen2;
    logic                dtack;
    logic                halt;
    logic [`KCPU_DW-1:0] din;
    wire                 cen_out;
    wire  [`KCPU_DW-1:0] dout;
    wire  [`KCPU_AW-1:0] addr;
    wire                 we;

    logic [`KCPU_DW-1:0] mem [0:(1<<`KCPU_AW)-1];
    logic [`KCPU_AW-1:0] exp_addr [$];
    logic [`KCPU_DW-1:0] exp_data [$];
    logic [`KCPU_AW-1:0] stop_pc;
    logic                exp_cen_out;
    integer              seed;
    int                  n_exp;
    int                  instr_cnt;
    int                  wr_idx;
    int                  halt_left;
    int                  cycles;
    int                  limit;

    kcpu dut_i (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .cen2    ( cen2    ),
        .dtack   ( dtack   ),
        .halt    ( halt    ),
        .din     ( din     ),
        .cen_out ( cen_out ),
        .dout    ( dout    ),
        .addr    ( addr    ),
        .we      ( we      )
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_addr(input string name, input logic [`KCPU_AW-1:0] exp,
                              input logic [`KCPU_AW-1:0] act);
        if (exp !== act) begin
            report_failure($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input logic [`KCPU_DW-1:0] exp,
                              input logic [`KCPU_DW-1:0] act);
        if (exp !== act) begin
            report_failure($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_op(input string name, input kcpu_op_e exp, input kcpu_op_e act);
        if (exp !== act) begin
            report_failure($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_strobe(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            report_failure($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // every byte differs from its neighbours in both address halves
    task automatic fill_memory();
        for (int i = 0; i < (1 << `KCPU_AW); i++) begin
            mem[i[15:0]] = i[15:8] ^ i[7:0] ^ 8'hA5;
        end
    endtask

    // count, then address high, address low and data per write
    task automatic load_expected();
        logic [`KCPU_AW-1:0] p;
        n_exp     = int'(mem[TBL_BASE]);
        stop_pc   = {mem[INFO_BASE], mem[INFO_BASE + 16'd1]};
        instr_cnt = int'({mem[INFO_BASE + 16'd2], mem[INFO_BASE + 16'd3]});
        p = TBL_BASE + 16'd1;
        for (int k = 0; k < n_exp; k++) begin
            exp_addr.push_back({mem[p], mem[p + 16'd1]});
            exp_data.push_back(mem[p + 16'd2]);
            p = p + 16'd3;
        end
    endtask

    task automatic drive_inputs();
        cen2  = ($random(seed) % 8) != 0;
        dtack = ($random(seed) % 4) != 0;
        din   = mem[addr];
        if (halt_left > 0) begin
            halt = 1'b1;
            halt_left--;
        end else begin
            halt = 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    initial begin
        forever begin
            @(posedge clk);
            #2;
            drive_inputs();
        end
    end

    // exported strobe is the acknowledged host strobe one clock later
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_cen_out <= 1'b0;
        end else begin
            exp_cen_out <= cen2 & dtack;
        end
    end

    // bus writes and cen_out are checked mid-cycle away from both edges
    always @(negedge clk) begin
        if (arst_n) begin
            check_strobe("cen_out", exp_cen_out, cen_out);
        end
        if (arst_n && we) begin
            if (halt) begin
                report_failure("a write happened while halt was holding the core");
            end else if (wr_idx >= n_exp) begin
                report_failure($sformatf("write to %h was not in the expected list", addr));
            end else begin
                if (wr_idx > 0) begin
                    check_addr($sformatf("write %0d x step", wr_idx),
                               exp_addr[wr_idx - 1] + 16'd1, addr);
                end
                check_addr($sformatf("write %0d address", wr_idx), exp_addr[wr_idx], addr);
                check_data($sformatf("write %0d data", wr_idx), exp_data[wr_idx], dout);
                mem[addr] = dout;
                wr_idx++;
                if (wr_idx == HALT_AFTER) begin
                    halt_left = HALT_CYCLES;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            report_failure($sformatf("timeout, the core did not stop within %0d cycles", limit));
        end
    end

    initial begin
        seed      = 32'h5a0ce464;
        arst_n    = 1'b0;
        cen2      = 1'b0;
        dtack     = 1'b0;
        halt      = 1'b0;
        din       = '0;
        wr_idx    = 0;
        halt_left = 0;
        cycles    = 0;
        limit     = 0;
        fill_memory();
        $readmemh("dv/kcpu_vectors.hex", mem);
        load_expected();
        // up to 4 cen pulses of 2 clocks each and 4x slack for dtack drops
        limit = instr_cnt * 4 * 2 * 4 + HALT_CYCLES + RST_CYCLES + TAIL_CYCLES;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        arst_n = 1'b1;
        while (dut_i.state != ST_STOPPED) begin
            @(negedge clk);
        end
        // any late write still gets caught by the monitor
        repeat (TAIL_CYCLES) @(negedge clk);
        check_addr("final pc", stop_pc, addr);
        check_op("stop opcode", OP_STOP, dut_i.op);
        if (wr_idx == n_exp) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            report_failure($sformatf("only %0d of %0d expected writes were seen", wr_idx, n_exp));
        end
    end

endmodule

`default_nettype wire

// ==== dv/kcpu_vectors.hex ====
// program bytes from 0000, final pc and executed instruction count at 7FFC
// write table at 8000: count, then address high, address low, data per write
@0000
8E 10 00    // LDX 1000
86 5A       // LDA 5A
A7          // STA
C6 C3       // LDB C3
E7          // STB
8B 37       // ADDA 37 gives 91
A7          // STA
80 A0       // SUBA A0 wraps to F1
A7          // STA
84 3C       // ANDA 3C gives 30
A7          // STA
8B E0       // ADDA E0 wraps to 10
A7          // STA
86 03       // LDA 03, loop counter
A7          // 0017 STA, loop top
80 01       // SUBA 01
26 FB       // BNE back to 0017
7E 00 22    // JMP 0022
86 EE A7    // skipped LDA EE and STA
12          // 0022 NOP
E7          // STB
3F          // STOP
@7FFC
00 25 00 1B
@8000
0A
10 00 5A  10 01 C3  10 02 91  10 03 F1  10 04 30
10 05 10  10 06 03  10 07 02  10 08 01  10 09 C3

// ==== hw/kcpu.sv ====
// kcpu top level, 8-bit core on one memory bus with a 16-bit address
`timescale 1ns/10ps
`default_nettype none

`include "kcpu_macros.svh"

module kcpu
    import kcpu_pkg::*;
(
    input  wire                clk,
    input  wire                arst_n,
    input  wire                cen2,
    input  wire                dtack,
    input  wire                halt,
    input  wire [`KCPU_DW-1:0] din,
    output wire                cen_out,
    output wire [`KCPU_DW-1:0] dout,
    output wire [`KCPU_AW-1:0] addr,
    output wire                we
);

    logic [`KCPU_DW-1:0] a, b, cc, cc_alu, rslt, mdata;
    logic [`KCPU_AW-1:0] x, pc;
    logic                cen;
    logic                fetch, opd, wrq, b_sel, incx, up_pc, pc_ld;
    logic                up_a, up_b, up_x_lo, up_x_hi, up_cc;
    kcpu_op_e            op;
    kcpu_alu_e           alu_sel;
    kcpu_state_e         state;

    kcpu_cen u_cen (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .cen2    ( cen2    ),
        .dtack   ( dtack   ),
        .cen     ( cen     ),
        .cen_out ( cen_out )
    );

    kcpu_ctrl u_ctrl (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .cen     ( cen     ),
        .halt    ( halt    ),
        .op      ( op      ),
        .cc      ( cc      ),
        .fetch   ( fetch   ),
        .opd     ( opd     ),
        .wrq     ( wrq     ),
        .b_sel   ( b_sel   ),
        .up_a    ( up_a    ),
        .up_b    ( up_b    ),
        .up_x_lo ( up_x_lo ),
        .up_x_hi ( up_x_hi ),
        .up_cc   ( up_cc   ),
        .incx    ( incx    ),
        .up_pc   ( up_pc   ),
        .pc_ld   ( pc_ld   ),
        .alu_sel ( alu_sel ),
        .state   ( state   )
    );

    kcpu_alu u_alu (
        .a       ( a       ),
        .mdata   ( mdata   ),
        .alu_sel ( alu_sel ),
        .cc_in   ( cc      ),
        .rslt    ( rslt    ),
        .cc_out  ( cc_alu  )
    );

    kcpu_regs u_regs (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .cen     ( cen     ),
        .rslt    ( rslt    ),
        .cc_alu  ( cc_alu  ),
        .mdata   ( mdata   ),
        .up_a    ( up_a    ),
        .up_b    ( up_b    ),
        .up_x_lo ( up_x_lo ),
        .up_x_hi ( up_x_hi ),
        .up_cc   ( up_cc   ),
        .incx    ( incx    ),
        .up_pc   ( up_pc   ),
        .pc_ld   ( pc_ld   ),
        .a       ( a       ),
        .b       ( b       ),
        .x       ( x       ),
        .pc      ( pc      ),
        .cc      ( cc      )
    );

    kcpu_memctrl u_memctrl (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .cen     ( cen     ),
        .fetch   ( fetch   ),
        .opd     ( opd     ),
        .wrq     ( wrq     ),
        .b_sel   ( b_sel   ),
        .pc      ( pc      ),
        .x       ( x       ),
        .a       ( a       ),
        .b       ( b       ),
        .din     ( din     ),
        .addr    ( addr    ),
        .dout    ( dout    ),
        .we      ( we      ),
        .op      ( op      ),
        .mdata   ( mdata   )
    );

endmodule

`default_nettype wire

// ==== hw/kcpu_alu.sv ====
// kcpu 8-bit ALU, pass, add, subtract and and with zero, negative and carry flags
`timescale 1ns/10ps
`default_nettype none

`include "kcpu_macros.svh"

module kcpu_alu
    import kcpu_pkg::*;
(
    input  wire [`KCPU_DW-1:0] a,
    input  wire [`KCPU_DW-1:0] mdata,
    input  wire kcpu_alu_e     alu_sel,
    input  wire [`KCPU_DW-1:0] cc_in,
    output logic [`KCPU_DW-1:0] rslt,
    output logic [`KCPU_DW-1:0] cc_out
);

    // one extra bit for carry and borrow
    logic [`KCPU_DW:0] sum;
    logic [`KCPU_DW:0] diff;

    assign sum  = {1'b0, a} + {1'b0, mdata};
    assign diff = {1'b0, a} - {1'b0, mdata};

    always_comb begin
        cc_out = cc_in;
        case (alu_sel)
            ALU_ADD: begin
                rslt         = sum[`KCPU_DW-1:0];
                cc_out[CC_C] = sum[`KCPU_DW];
            end
            ALU_SUB: begin
                rslt         = diff[`KCPU_DW-1:0];
                // borrow shows up as the top bit of the wide difference
                cc_out[CC_C] = diff[`KCPU_DW];
            end
            ALU_AND: rslt = a & mdata;
            default: rslt = mdata;
        endcase
        cc_out[CC_Z] = rslt == '0;
        cc_out[CC_N] = rslt[`KCPU_DW-1];
    end

endmodule

`default_nettype wire

// ==== hw/kcpu_cen.sv ====
// kcpu clock-enable timer, halves the host strobe and holds it off while dtack is low
`timescale 1ns/10ps
`default_nettype none

module kcpu_cen (
    input  wire  clk,
    input  wire  arst_n,
    input  wire  cen2,
    input  wire  dtack,
    output logic cen,
    output logic cen_out
);

    logic phase;
    logic qual;

    // host strobe only counts when memory has acknowledged
    assign qual = cen2 & dtack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase   <= 1'b0;
            cen     <= 1'b0;
            cen_out <= 1'b0;
        end else begin
            if (qual) begin
                phase <= ~phase;
            end
            // every second qualified strobe becomes a core step
            cen     <= qual & phase;
            cen_out <= qual;
        end
    end

endmodule

`default_nettype wire

// ==== hw/kcpu_ctrl.sv ====
// kcpu control FSM, sequences fetch, operand, execute and store steps
`timescale 1ns/10ps
`default_nettype none

`include "kcpu_macros.svh"

module kcpu_ctrl
    import kcpu_pkg::*;
(
    input  wire                clk,
    input  wire                arst_n,
    input  wire                cen,
    input  wire                halt,
    input  wire kcpu_op_e      op,
    input  wire [`KCPU_DW-1:0] cc,
    output logic               fetch,
    output logic               opd,
    output logic               wrq,
    output logic               b_sel,
    output logic               up_a,
    output logic               up_b,
    output logic               up_x_lo,
    output logic               up_x_hi,
    output logic               up_cc,
    output logic               incx,
    output logic               up_pc,
    output logic               pc_ld,
    output kcpu_alu_e          alu_sel,
    output kcpu_state_e        state
);

    kcpu_state_e nx_state;
    logic        two_byte;

    // LDX and JMP carry a 16-bit operand, high byte first
    assign two_byte = (op == OP_LDX) || (op == OP_JMP);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_FETCH;
        end else if (cen) begin
            state <= nx_state;
        end
    end

    always_comb begin
        nx_state = state;
        fetch    = 1'b0;
        opd      = 1'b0;
        wrq      = 1'b0;
        b_sel    = 1'b0;
        up_a     = 1'b0;
        up_b     = 1'b0;
        up_x_lo  = 1'b0;
        up_x_hi  = 1'b0;
        up_cc    = 1'b0;
        incx     = 1'b0;
        up_pc    = 1'b0;
        pc_ld    = 1'b0;
        alu_sel  = ALU_PASS;
        case (state)
            ST_FETCH: begin
                // halt only takes effect between instructions
                if (!halt) begin
                    fetch = 1'b1;
                    up_pc = 1'b1;
                    // op is the byte on din during this step
                    case (op)
                        OP_LDA, OP_LDB, OP_ADDA, OP_SUBA, OP_ANDA, OP_BNE: begin
                            nx_state = ST_OPND_LO;
                        end
                        OP_LDX, OP_JMP: nx_state = ST_OPND_HI;
                        OP_STA, OP_STB: nx_state = ST_STORE;
                        OP_STOP:        nx_state = ST_STOPPED;
                        default:        nx_state = ST_FETCH;
                    endcase
                end
            end
            ST_OPND_HI: begin
                opd      = 1'b1;
                up_pc    = 1'b1;
                nx_state = ST_OPND_LO;
            end
            ST_OPND_LO: begin
                opd      = 1'b1;
                up_pc    = 1'b1;
                // previous operand byte moves to the holding byte
                up_x_hi  = two_byte;
                nx_state = ST_EXEC;
            end
            ST_EXEC: begin
                nx_state = ST_FETCH;
                case (op)
                    OP_LDA: begin
                        up_a  = 1'b1;
                        up_cc = 1'b1;
                    end
                    OP_LDB: begin
                        up_b  = 1'b1;
                        up_cc = 1'b1;
                    end
                    OP_ADDA: begin
                        alu_sel = ALU_ADD;
                        up_a    = 1'b1;
                        up_cc   = 1'b1;
                    end
                    OP_SUBA: begin
                        alu_sel = ALU_SUB;
                        up_a    = 1'b1;
                        up_cc   = 1'b1;
                    end
                    OP_ANDA: begin
                        alu_sel = ALU_AND;
                        up_a    = 1'b1;
                        up_cc   = 1'b1;
                    end
                    OP_LDX:  up_x_lo = 1'b1;
                    OP_BNE:  pc_ld   = ~cc[CC_Z];
                    OP_JMP:  pc_ld   = 1'b1;
                    default: ;
                endcase
            end
            ST_STORE: begin
                wrq      = 1'b1;
                incx     = 1'b1;
                b_sel    = op == OP_STB;
                nx_state = ST_FETCH;
            end
            ST_STOPPED: nx_state = ST_STOPPED;
            default:    nx_state = ST_FETCH;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/kcpu_macros.svh ====
// kcpu core fixed bus widths, reset vector and stop opcode value
`ifndef KCPU_MACROS_SVH
`define KCPU_MACROS_SVH

// data bus and accumulator width
`define KCPU_DW      8

// memory bus address width, also the width of X and PC
`define KCPU_AW      16

// first fetch after reset
`define KCPU_RST_PC  16'h0000

// stops the core until the next reset
`define KCPU_OP_STOP 8'h3F

`endif

// ==== hw/kcpu_memctrl.sv ====
// kcpu memory controller, bus address select, write data and read byte capture
`timescale 1ns/10ps
`default_nettype none

`include "kcpu_macros.svh"

module kcpu_memctrl
    import kcpu_pkg::*;
(
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 cen,
    input  wire                 fetch,
    input  wire                 opd,
    input  wire                 wrq,
    input  wire                 b_sel,
    input  wire  [`KCPU_AW-1:0] pc,
    input  wire  [`KCPU_AW-1:0] x,
    input  wire  [`KCPU_DW-1:0] a,
    input  wire  [`KCPU_DW-1:0] b,
    input  wire  [`KCPU_DW-1:0] din,
    output logic [`KCPU_AW-1:0] addr,
    output logic [`KCPU_DW-1:0] dout,
    output logic                we,
    output kcpu_op_e            op,
    output logic [`KCPU_DW-1:0] mdata
);

    kcpu_op_e op_q;

    // stores go to X, every read comes from PC
    assign addr = wrq ? x : pc;
    assign dout = b_sel ? b : a;
    assign we   = wrq & cen;

    // fetch cycle decodes straight from the bus
    assign op   = fetch ? kcpu_op_e'(din) : op_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_q <= OP_NOP;
        end else if (cen && fetch) begin
            op_q <= kcpu_op_e'(din);
        end
    end

    always_ff @(posedge clk) begin
        if (cen && opd) begin
            mdata <= din;
        end
    end

endmodule

`default_nettype wire

// ==== hw/kcpu_pkg.sv ====
// kcpu shared types: control states, opcodes, ALU functions and flag positions
`default_nettype none

`include "kcpu_macros.svh"

package kcpu_pkg;

    // one state per cen pulse
    typedef enum logic [2:0] {
        ST_FETCH   = 3'd0,
        ST_OPND_LO = 3'd1,
        ST_OPND_HI = 3'd2,
        ST_EXEC    = 3'd3,
        ST_STORE   = 3'd4,
        ST_STOPPED = 3'd5
    } kcpu_state_e;

    // 6809-flavoured encodings, anything else runs as NOP
    typedef enum logic [`KCPU_DW-1:0] {
        OP_NOP  = 8'h12,
        OP_LDA  = 8'h86,
        OP_LDB  = 8'hC6,
        OP_LDX  = 8'h8E,
        OP_ADDA = 8'h8B,
        OP_SUBA = 8'h80,
        OP_ANDA = 8'h84,
        OP_STA  = 8'hA7,
        OP_STB  = 8'hE7,
        OP_BNE  = 8'h26,
        OP_JMP  = 8'h7E,
        OP_STOP = `KCPU_OP_STOP
    } kcpu_op_e;

    typedef enum logic [1:0] {
        ALU_PASS = 2'd0,
        ALU_ADD  = 2'd1,
        ALU_SUB  = 2'd2,
        ALU_AND  = 2'd3
    } kcpu_alu_e;

    // flag positions in cc
    localparam int CC_C = 0;
    localparam int CC_Z = 2;
    localparam int CC_N = 3;

endpackage

`default_nettype wire

// ==== hw/kcpu_regs.sv ====
// kcpu programmer registers A, B, X, PC and CC with the PC and X incrementers
`timescale 1ns/10ps
`default_nettype none

`include "kcpu_macros.svh"

module kcpu_regs (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 cen,
    input  wire  [`KCPU_DW-1:0] rslt,
    input  wire  [`KCPU_DW-1:0] cc_alu,
    input  wire  [`KCPU_DW-1:0] mdata,
    input  wire                 up_a,
    input  wire                 up_b,
    input  wire                 up_x_lo,
    input  wire                 up_x_hi,
    input  wire                 up_cc,
    input  wire                 incx,
    input  wire                 up_pc,
    input  wire                 pc_ld,
    output logic [`KCPU_DW-1:0] a,
    output logic [`KCPU_DW-1:0] b,
    output logic [`KCPU_AW-1:0] x,
    output logic [`KCPU_AW-1:0] pc,
    output logic [`KCPU_DW-1:0] cc
);

    localparam logic [`KCPU_AW-1:0] STEP = 1;

    logic [`KCPU_DW-1:0] x_hold;
    logic                hold_full;
    logic [`KCPU_AW-1:0] opnd16;
    logic [`KCPU_AW-1:0] rel16;

    assign opnd16 = {x_hold, mdata};
    // branch offset is signed
    assign rel16  = {{(`KCPU_AW-`KCPU_DW){mdata[`KCPU_DW-1]}}, mdata};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc        <= `KCPU_RST_PC;
            cc        <= '0;
            hold_full <= 1'b0;
        end else if (cen) begin
            // a pending high byte means a JMP, otherwise the load is a branch
            if (pc_ld) begin
                pc <= hold_full ? opnd16 : pc + rel16;
            end else if (up_pc) begin
                pc <= pc + STEP;
            end
            if (up_cc) begin
                cc <= cc_alu;
            end
            if (up_x_hi) begin
                hold_full <= 1'b1;
            end else if (up_x_lo || pc_ld) begin
                hold_full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            if (up_a) begin
                a <= rslt;
            end
            if (up_b) begin
                b <= rslt;
            end
            if (up_x_hi) begin
                x_hold <= mdata;
            end
            // post-increment after each store
            if (up_x_lo) begin
                x <= opnd16;
            end else if (incx) begin
                x <= x + STEP;
            end
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/kcpu_pkg.sv
hw/kcpu_cen.sv
hw/kcpu_ctrl.sv
hw/kcpu_alu.sv
hw/kcpu_regs.sv
hw/kcpu_memctrl.sv
hw/kcpu.sv
dv/kcpu_props.sv
dv/kcpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the kcpu testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert --top-module kcpu_tb -f project.f -o kcpu_sim > build.log 2>&1 \
    && ./obj_dir/kcpu_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
echo "simulation finished without failure"
exit 0
